//--- mips_pkg.sv
package mips_pkg;

  localparam int WORD_W     = 32;  // Instruction and default data width
  localparam int OPCODE_W   = 6;
  localparam int FUNCT_W    = 6;
  localparam int REG_ADDR_W = 5;
  localparam int IMM_W      = 16;
  localparam int LOAD_W     = 3;   // Load-extension code width

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [OPCODE_W-1:0]   opcode_t;
  typedef logic [FUNCT_W-1:0]    funct_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [IMM_W-1:0]      imm_t;
  typedef logic [LOAD_W-1:0]     load_ctrl_t;

  localparam int        REG_COUNT = 32;
  localparam reg_addr_t RA_REG    = 5'd31;  // Link register

  // Load-extension codes, 4 is unused
  localparam load_ctrl_t LD_B  = 3'd0;  // Byte signed
  localparam load_ctrl_t LD_BU = 3'd1;  // Byte unsigned
  localparam load_ctrl_t LD_H  = 3'd2;
  localparam load_ctrl_t LD_HU = 3'd3;
  localparam load_ctrl_t LD_W  = 3'd5;
  localparam load_ctrl_t LD_WL = 3'd6;  // Word left
  localparam load_ctrl_t LD_WR = 3'd7;  // Word right

  typedef enum logic [1:0] {
    DST_RT = 2'b00,  // I-type target
    DST_RD = 2'b01,  // R-type target
    DST_RA = 2'b10   // Link to r31
  } dst_sel_t;

  typedef enum logic [1:0] {
    ALUOP_ADD   = 2'b00,  // Address calc and jumps
    ALUOP_SUB   = 2'b01,  // Branch compare
    ALUOP_FUNCT = 2'b10,  // Look up funct
    ALUOP_IMM   = 2'b11   // Look up opcode
  } aluop_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
    ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL,
    ALU_SRA, ALU_LUI, ALU_PASSA
  } alu_ctrl_t;

  localparam opcode_t OP_RTYPE  = 6'b000000;
  localparam opcode_t OP_REGIMM = 6'b000001;
  localparam opcode_t OP_J      = 6'b000010;
  localparam opcode_t OP_JAL    = 6'b000011;
  localparam opcode_t OP_BEQ    = 6'b000100;
  localparam opcode_t OP_BNE    = 6'b000101;
  localparam opcode_t OP_BLEZ   = 6'b000110;
  localparam opcode_t OP_BGTZ   = 6'b000111;
  localparam opcode_t OP_ADDIU  = 6'b001001;
  localparam opcode_t OP_SLTI   = 6'b001010;
  localparam opcode_t OP_SLTIU  = 6'b001011;
  localparam opcode_t OP_ANDI   = 6'b001100;
  localparam opcode_t OP_ORI    = 6'b001101;
  localparam opcode_t OP_XORI   = 6'b001110;
  localparam opcode_t OP_LUI    = 6'b001111;
  localparam opcode_t OP_LB     = 6'b100000;
  localparam opcode_t OP_LH     = 6'b100001;
  localparam opcode_t OP_LWL    = 6'b100010;
  localparam opcode_t OP_LW     = 6'b100011;
  localparam opcode_t OP_LBU    = 6'b100100;
  localparam opcode_t OP_LHU    = 6'b100101;
  localparam opcode_t OP_LWR    = 6'b100110;
  localparam opcode_t OP_SB     = 6'b101000;
  localparam opcode_t OP_SH     = 6'b101001;
  localparam opcode_t OP_SW     = 6'b101011;

  localparam funct_t FN_SLL  = 6'b000000;
  localparam funct_t FN_SRL  = 6'b000010;
  localparam funct_t FN_SRA  = 6'b000011;
  localparam funct_t FN_JR   = 6'b001000;
  localparam funct_t FN_JALR = 6'b001001;
  localparam funct_t FN_MTHI = 6'b010001;
  localparam funct_t FN_MTLO = 6'b010011;
  localparam funct_t FN_ADD  = 6'b100000;
  localparam funct_t FN_ADDU = 6'b100001;
  localparam funct_t FN_SUB  = 6'b100010;
  localparam funct_t FN_SUBU = 6'b100011;
  localparam funct_t FN_AND  = 6'b100100;
  localparam funct_t FN_OR   = 6'b100101;
  localparam funct_t FN_XOR  = 6'b100110;
  localparam funct_t FN_NOR  = 6'b100111;
  localparam funct_t FN_SLT  = 6'b101010;
  localparam funct_t FN_SLTU = 6'b101011;

  // REGIMM branch selectors in the rt field
  localparam reg_addr_t RT_BLTZ   = 5'b00000;
  localparam reg_addr_t RT_BGEZ   = 5'b00001;
  localparam reg_addr_t RT_BLTZAL = 5'b10000;
  localparam reg_addr_t RT_BGEZAL = 5'b10001;

endpackage

//--- ctrl_if.sv
`timescale 1ns/1ns

interface ctrl_if;

  logic                 reg_write;   // Writes a GPR
  mips_pkg::dst_sel_t   dst_sel;     // Which field names the target
  logic                 alu_src;     // Immediate as ALU operand B
  logic                 branch;
  logic                 mem_write;
  logic                 mem_to_reg;  // Result from memory
  logic                 jump;
  logic                 jump_reg;    // Target comes from rs
  mips_pkg::aluop_t     aluop;
  mips_pkg::load_ctrl_t load_ctrl;
  logic                 illegal;     // Undefined encoding

  modport dec (
    output reg_write, dst_sel, alu_src, branch,
    output mem_write, mem_to_reg, jump, jump_reg,
    output aluop, load_ctrl, illegal
  );

  modport user (
    input reg_write, dst_sel, alu_src, branch,
    input mem_write, mem_to_reg, jump, jump_reg,
    input aluop, load_ctrl, illegal
  );

endinterface

//--- maindec.sv
`timescale 1ns/1ns

module maindec (
  input  mips_pkg::opcode_t   op,
  input  mips_pkg::funct_t    funct,
  input  mips_pkg::reg_addr_t rt,     // REGIMM selector
  ctrl_if.dec                 ctrl
);

  always_comb begin
    // All quiet unless an opcode below turns something on
    ctrl.reg_write  = 1'b0;
    ctrl.dst_sel    = mips_pkg::DST_RT;
    ctrl.alu_src    = 1'b0;
    ctrl.branch     = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.mem_to_reg = 1'b0;
    ctrl.jump       = 1'b0;
    ctrl.jump_reg   = 1'b0;
    ctrl.aluop      = mips_pkg::ALUOP_ADD;
    ctrl.illegal    = 1'b0;

    case (op)
      mips_pkg::OP_RTYPE: begin
        ctrl.aluop = mips_pkg::ALUOP_FUNCT;  // JR/JALR resolve to pass-a
        case (funct)
          mips_pkg::FN_JR: begin
            ctrl.jump     = 1'b1;
            ctrl.jump_reg = 1'b1;
          end
          mips_pkg::FN_JALR: begin
            ctrl.reg_write = 1'b1;
            ctrl.dst_sel   = mips_pkg::DST_RA;  // Link always in r31
            ctrl.jump      = 1'b1;
            ctrl.jump_reg  = 1'b1;
          end
          mips_pkg::FN_MTHI, mips_pkg::FN_MTLO: begin
            ctrl.reg_write = 1'b0;  // HI/LO live outside the GPRs
          end
          default: begin
            ctrl.reg_write = 1'b1;  // Plain ALU op into rd
            ctrl.dst_sel   = mips_pkg::DST_RD;
          end
        endcase
      end

      mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_LH, mips_pkg::OP_LHU,
      mips_pkg::OP_LW, mips_pkg::OP_LWL, mips_pkg::OP_LWR: begin
        ctrl.reg_write  = 1'b1;
        ctrl.alu_src    = 1'b1;  // Base plus offset
        ctrl.mem_to_reg = 1'b1;
      end

      mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end

      mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ: begin
        ctrl.branch = 1'b1;
        ctrl.aluop  = mips_pkg::ALUOP_SUB;
      end

      mips_pkg::OP_REGIMM: begin
        case (rt)
          mips_pkg::RT_BLTZ, mips_pkg::RT_BGEZ: begin
            ctrl.branch = 1'b1;
            ctrl.aluop  = mips_pkg::ALUOP_SUB;
          end
          mips_pkg::RT_BLTZAL, mips_pkg::RT_BGEZAL: begin
            ctrl.branch    = 1'b1;
            ctrl.aluop     = mips_pkg::ALUOP_SUB;
            ctrl.reg_write = 1'b1;  // Return address into r31
            ctrl.dst_sel   = mips_pkg::DST_RA;
          end
          default: ctrl.illegal = 1'b1;  // Unknown rt code
        endcase
      end

      mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI,
      mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.aluop     = mips_pkg::ALUOP_IMM;  // aludec picks by opcode
      end

      mips_pkg::OP_J: ctrl.jump = 1'b1;
      mips_pkg::OP_JAL: begin
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = mips_pkg::DST_RA;
      end

      default: ctrl.illegal = 1'b1;  // Control word stays zero
    endcase
  end

  // Extension code matters only for loads
  always_comb begin
    case (op)
      mips_pkg::OP_LBU: ctrl.load_ctrl = mips_pkg::LD_BU;
      mips_pkg::OP_LH:  ctrl.load_ctrl = mips_pkg::LD_H;
      mips_pkg::OP_LHU: ctrl.load_ctrl = mips_pkg::LD_HU;
      mips_pkg::OP_LW:  ctrl.load_ctrl = mips_pkg::LD_W;
      mips_pkg::OP_LWL: ctrl.load_ctrl = mips_pkg::LD_WL;
      mips_pkg::OP_LWR: ctrl.load_ctrl = mips_pkg::LD_WR;
      default:          ctrl.load_ctrl = mips_pkg::LD_B;  // LB and non-loads
    endcase
  end

endmodule

//--- aludec.sv
`timescale 1ns/1ns

module aludec (
  input  mips_pkg::opcode_t   op,
  input  mips_pkg::funct_t    funct,
  ctrl_if.user                ctrl,      // Only aluop is used here
  output mips_pkg::alu_ctrl_t alu_ctrl
);

  mips_pkg::alu_ctrl_t funct_ctrl;  // R-type lookup
  mips_pkg::alu_ctrl_t imm_ctrl;    // Immediate-op lookup

  always_comb begin
    case (funct)
      mips_pkg::FN_ADD:  funct_ctrl = mips_pkg::ALU_ADD;
      mips_pkg::FN_ADDU: funct_ctrl = mips_pkg::ALU_ADDU;
      mips_pkg::FN_SUB:  funct_ctrl = mips_pkg::ALU_SUB;
      mips_pkg::FN_SUBU: funct_ctrl = mips_pkg::ALU_SUBU;
      mips_pkg::FN_AND:  funct_ctrl = mips_pkg::ALU_AND;
      mips_pkg::FN_OR:   funct_ctrl = mips_pkg::ALU_OR;
      mips_pkg::FN_XOR:  funct_ctrl = mips_pkg::ALU_XOR;
      mips_pkg::FN_NOR:  funct_ctrl = mips_pkg::ALU_NOR;
      mips_pkg::FN_SLT:  funct_ctrl = mips_pkg::ALU_SLT;
      mips_pkg::FN_SLTU: funct_ctrl = mips_pkg::ALU_SLTU;
      mips_pkg::FN_SLL:  funct_ctrl = mips_pkg::ALU_SLL;
      mips_pkg::FN_SRL:  funct_ctrl = mips_pkg::ALU_SRL;
      mips_pkg::FN_SRA:  funct_ctrl = mips_pkg::ALU_SRA;
      // Jump target and HI/LO source all pass rs straight through
      mips_pkg::FN_JR, mips_pkg::FN_JALR,
      mips_pkg::FN_MTHI, mips_pkg::FN_MTLO: funct_ctrl = mips_pkg::ALU_PASSA;
      default:           funct_ctrl = mips_pkg::ALU_ADD;  // Unlisted funct
    endcase
  end

  always_comb begin
    case (op)
      mips_pkg::OP_ADDIU: imm_ctrl = mips_pkg::ALU_ADDU;
      mips_pkg::OP_ANDI:  imm_ctrl = mips_pkg::ALU_AND;
      mips_pkg::OP_ORI:   imm_ctrl = mips_pkg::ALU_OR;
      mips_pkg::OP_XORI:  imm_ctrl = mips_pkg::ALU_XOR;
      mips_pkg::OP_SLTI:  imm_ctrl = mips_pkg::ALU_SLT;
      mips_pkg::OP_SLTIU: imm_ctrl = mips_pkg::ALU_SLTU;
      mips_pkg::OP_LUI:   imm_ctrl = mips_pkg::ALU_LUI;
      default:            imm_ctrl = mips_pkg::ALU_ADD;
    endcase
  end

  always_comb begin
    case (ctrl.aluop)
      mips_pkg::ALUOP_ADD:   alu_ctrl = mips_pkg::ALU_ADD;
      mips_pkg::ALUOP_SUB:   alu_ctrl = mips_pkg::ALU_SUB;  // Compare for branches
      mips_pkg::ALUOP_FUNCT: alu_ctrl = funct_ctrl;
      mips_pkg::ALUOP_IMM:   alu_ctrl = imm_ctrl;
      default:               alu_ctrl = mips_pkg::ALU_ADD;
    endcase
  end

endmodule

//--- regfile.sv
`timescale 1ns/1ns

module regfile #(
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  input  mips_pkg::reg_addr_t ra1,   // rs read port
  input  mips_pkg::reg_addr_t ra2,   // rt read port
  output logic [DATA_W-1:0]   rd1,
  output logic [DATA_W-1:0]   rd2,
  input  logic                we,    // Writeback strobe
  input  mips_pkg::reg_addr_t wa,
  input  logic [DATA_W-1:0]   wd
);

  logic [DATA_W-1:0] regs [1:mips_pkg::REG_COUNT-1];  // No storage for r0

  function automatic logic [DATA_W-1:0] read_port(input mips_pkg::reg_addr_t ra);
    logic [DATA_W-1:0] val;
    if (ra == '0) begin
      val = '0;                                  // r0 reads zero
    end else if (we && (wa == ra)) begin
      val = wd;                                  // Write-first bypass
    end else begin
      val = regs[ra];
    end
    return val;
  endfunction

  always_comb rd1 = read_port(ra1);
  always_comb rd2 = read_port(ra2);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < mips_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;                            // Writes to r0 dropped
    end
  end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage #(
  parameter int DATA_W = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,   // One-cycle strobe
  input  mips_pkg::word_t      instr,
  input  logic                 wb_en,
  input  mips_pkg::reg_addr_t  wb_addr,
  input  logic [DATA_W-1:0]    wb_data,
  output logic                 ex_valid,
  output logic                 ex_reg_write,
  output mips_pkg::reg_addr_t  ex_dst,
  output logic                 ex_alu_src,
  output logic                 ex_branch,
  output logic                 ex_mem_write,
  output logic                 ex_mem_to_reg,
  output logic                 ex_jump,
  output logic                 ex_jump_reg,
  output mips_pkg::alu_ctrl_t  ex_alu_ctrl,
  output mips_pkg::load_ctrl_t ex_load_ctrl,
  output logic                 ex_illegal,
  output logic [DATA_W-1:0]    ex_rs_data,
  output logic [DATA_W-1:0]    ex_rt_data,
  output logic [DATA_W-1:0]    ex_imm
);

  logic                id_valid;   // IF/ID occupancy
  mips_pkg::word_t     id_instr;
  mips_pkg::opcode_t   op;
  mips_pkg::funct_t    funct;
  mips_pkg::reg_addr_t rs;
  mips_pkg::reg_addr_t rt;
  mips_pkg::reg_addr_t rd;
  mips_pkg::reg_addr_t dst;
  mips_pkg::imm_t      imm;
  logic [DATA_W-1:0]   imm_x;      // Extended immediate
  logic [DATA_W-1:0]   rs_data;
  logic [DATA_W-1:0]   rt_data;
  mips_pkg::alu_ctrl_t alu_ctrl;

  ctrl_if ctrl_d ();               // Combinational decode result

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid <= 1'b0;
    end else begin
      id_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) id_instr <= instr;  // Hold last word between strobes
  end

  assign op    = id_instr[31:26];
  assign rs    = id_instr[25:21];
  assign rt    = id_instr[20:16];
  assign rd    = id_instr[15:11];
  assign imm   = id_instr[15:0];
  assign funct = id_instr[5:0];

  maindec u_maindec (.op(op), .funct(funct), .rt(rt), .ctrl(ctrl_d.dec));

  aludec u_aludec (.op(op), .funct(funct), .ctrl(ctrl_d.user), .alu_ctrl(alu_ctrl));

  regfile #(.DATA_W(DATA_W)) u_regfile (
    .clk(clk), .rst_n(rst_n),
    .ra1(rs), .ra2(rt), .rd1(rs_data), .rd2(rt_data),
    .we(wb_en), .wa(wb_addr), .wd(wb_data)
  );

  always_comb begin
    case (ctrl_d.dst_sel)
      mips_pkg::DST_RD: dst = rd;
      mips_pkg::DST_RA: dst = mips_pkg::RA_REG;
      default:          dst = rt;
    endcase
  end

  // Logical immediates zero-extend, LUI fills the upper half
  always_comb begin
    case (op)
      mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: imm_x = DATA_W'(imm);
      mips_pkg::OP_LUI: imm_x = DATA_W'({imm, 16'h0000});
      default:          imm_x = DATA_W'($signed(imm));  // Sign-extend
    endcase
  end

  // Bubbles clear every control bit so no write leaks through
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid      <= 1'b0;
      ex_reg_write  <= 1'b0;
      ex_alu_src    <= 1'b0;
      ex_branch     <= 1'b0;
      ex_mem_write  <= 1'b0;
      ex_mem_to_reg <= 1'b0;
      ex_jump       <= 1'b0;
      ex_jump_reg   <= 1'b0;
      ex_illegal    <= 1'b0;
    end else begin
      ex_valid      <= id_valid;
      ex_reg_write  <= id_valid & ctrl_d.reg_write;
      ex_alu_src    <= id_valid & ctrl_d.alu_src;
      ex_branch     <= id_valid & ctrl_d.branch;
      ex_mem_write  <= id_valid & ctrl_d.mem_write;
      ex_mem_to_reg <= id_valid & ctrl_d.mem_to_reg;
      ex_jump       <= id_valid & ctrl_d.jump;
      ex_jump_reg   <= id_valid & ctrl_d.jump_reg;
      ex_illegal    <= id_valid & ctrl_d.illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (id_valid) begin            // Payload only moves with a valid slot
      ex_dst       <= dst;
      ex_alu_ctrl  <= alu_ctrl;
      ex_load_ctrl <= ctrl_d.load_ctrl;
      ex_rs_data   <= rs_data;
      ex_rt_data   <= rt_data;
      ex_imm       <= imm_x;
    end
  end

endmodule

//--- mips_decode_top.sv
`timescale 1ns/1ns

module mips_decode_top #(
  parameter int DATA_W = 32        // 64 also supported
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  mips_pkg::word_t      instr,
  input  logic                 wb_en,          // Writeback from later stage
  input  mips_pkg::reg_addr_t  wb_addr,
  input  logic [DATA_W-1:0]    wb_data,
  output logic                 ex_valid,
  output logic                 ex_reg_write,
  output mips_pkg::reg_addr_t  ex_dst,         // r31 for links
  output logic                 ex_alu_src,
  output logic                 ex_branch,
  output logic                 ex_mem_write,
  output logic                 ex_mem_to_reg,
  output logic                 ex_jump,
  output logic                 ex_jump_reg,
  output mips_pkg::alu_ctrl_t  ex_alu_ctrl,
  output mips_pkg::load_ctrl_t ex_load_ctrl,
  output logic                 ex_illegal,
  output logic [DATA_W-1:0]    ex_rs_data,
  output logic [DATA_W-1:0]    ex_rt_data,
  output logic [DATA_W-1:0]    ex_imm
);

  decode_stage #(.DATA_W(DATA_W)) u_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data),
    .ex_valid     (ex_valid),
    .ex_reg_write (ex_reg_write),
    .ex_dst       (ex_dst),
    .ex_alu_src   (ex_alu_src),
    .ex_branch    (ex_branch),
    .ex_mem_write (ex_mem_write),
    .ex_mem_to_reg(ex_mem_to_reg),
    .ex_jump      (ex_jump),
    .ex_jump_reg  (ex_jump_reg),
    .ex_alu_ctrl  (ex_alu_ctrl),
    .ex_load_ctrl (ex_load_ctrl),
    .ex_illegal   (ex_illegal),
    .ex_rs_data   (ex_rs_data),
    .ex_rt_data   (ex_rt_data),
    .ex_imm       (ex_imm)
  );

endmodule

//--- mips_decode_assertions.sv
`timescale 1ns/1ns

module mips_decode_assertions (
  input logic clk,
  input logic rst_n,
  input logic instr_valid,
  input logic ex_valid,
  input logic ex_reg_write,
  input logic ex_mem_write,
  input logic ex_branch,
  input logic ex_jump,
  input logic ex_jump_reg,
  input logic ex_illegal
);

  int n_fail = 0;  // Failure count, read at end of run

  // Sampled mid-cycle so the async clear has settled
  a_reset_idle: assert property (@(negedge clk) !rst_n |-> !ex_valid)
    else begin
      $error("ex_valid high while reset is asserted");
      n_fail++;
    end

  a_bubble_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_valid |-> !(ex_reg_write || ex_mem_write || ex_branch || ex_jump || ex_jump_reg))
    else begin
      $error("Control output active in a bubble");
      n_fail++;
    end

  a_illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    ex_illegal |-> !(ex_reg_write || ex_mem_write || ex_branch || ex_jump))
    else begin
      $error("Illegal instruction carries a write, branch or jump");
      n_fail++;
    end

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid == $past(instr_valid, 2))  // Fixed two-edge latency
    else begin
      $error("ex_valid does not follow instr_valid by two cycles");
      n_fail++;
    end

endmodule

//--- tb_mips_decode.sv
`timescale 1ns/1ns

module tb_mips_decode;

  localparam int DATA_W      = 32;
  localparam int MAX_STEPS   = 620;                   // Upper bound on driven cycles
  localparam int TIMEOUT_CYC = 4 * MAX_STEPS + 200;

  typedef struct packed {
    logic                 reg_write;
    mips_pkg::reg_addr_t  dst;
    logic                 alu_src;
    logic                 branch;
    logic                 mem_write;
    logic                 mem_to_reg;
    logic                 jump;
    logic                 jump_reg;
    mips_pkg::alu_ctrl_t  alu_ctrl;
    mips_pkg::load_ctrl_t load_ctrl;
    logic                 illegal;
    mips_pkg::word_t      rs_data;
    mips_pkg::word_t      rt_data;
    mips_pkg::word_t      imm;
  } exp_t;

  logic                 clk;
  logic                 rst_n;
  logic                 instr_valid;
  mips_pkg::word_t      instr;
  logic                 wb_en;
  mips_pkg::reg_addr_t  wb_addr;
  mips_pkg::word_t      wb_data;
  logic                 ex_valid;
  logic                 ex_reg_write;
  mips_pkg::reg_addr_t  ex_dst;
  logic                 ex_alu_src;
  logic                 ex_branch;
  logic                 ex_mem_write;
  logic                 ex_mem_to_reg;
  logic                 ex_jump;
  logic                 ex_jump_reg;
  mips_pkg::alu_ctrl_t  ex_alu_ctrl;
  mips_pkg::load_ctrl_t ex_load_ctrl;
  logic                 ex_illegal;
  mips_pkg::word_t      ex_rs_data;
  mips_pkg::word_t      ex_rt_data;
  mips_pkg::word_t      ex_imm;

  integer          seed;
  int              cycles = 0;
  mips_pkg::word_t rf_model [0:31];   // Software register file
  exp_t            exp_q [$];         // Results waiting for ex_valid
  logic            prev_valid;        // Slot driven one cycle back
  mips_pkg::word_t prev_instr;
  logic [1:0]      v_hist = 2'b00;    // instr_valid of the last two cycles

  mips_pkg::opcode_t op_list [0:24] = '{
    mips_pkg::OP_RTYPE, mips_pkg::OP_REGIMM, mips_pkg::OP_J, mips_pkg::OP_JAL,
    mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ,
    mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI,
    mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI, mips_pkg::OP_LB,
    mips_pkg::OP_LH, mips_pkg::OP_LWL, mips_pkg::OP_LW, mips_pkg::OP_LBU,
    mips_pkg::OP_LHU, mips_pkg::OP_LWR, mips_pkg::OP_SB, mips_pkg::OP_SH,
    mips_pkg::OP_SW
  };

  mips_decode_top #(.DATA_W(DATA_W)) UUT (.*);

  bind decode_stage mips_decode_assertions u_asrt (
    .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .ex_valid(ex_valid),
    .ex_reg_write(ex_reg_write), .ex_mem_write(ex_mem_write), .ex_branch(ex_branch),
    .ex_jump(ex_jump), .ex_jump_reg(ex_jump_reg), .ex_illegal(ex_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                           // 20 ns period
  end

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_dst(input string name, input mips_pkg::reg_addr_t exp,
                           input mips_pkg::reg_addr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input mips_pkg::word_t exp,
                            input mips_pkg::word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_alu(input string name, input mips_pkg::alu_ctrl_t exp,
                           input mips_pkg::alu_ctrl_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_load(input string name, input mips_pkg::load_ctrl_t exp,
                            input mips_pkg::load_ctrl_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  function automatic mips_pkg::alu_ctrl_t funct_alu(input mips_pkg::funct_t fn);
    case (fn)
      mips_pkg::FN_ADD:  return mips_pkg::ALU_ADD;
      mips_pkg::FN_ADDU: return mips_pkg::ALU_ADDU;
      mips_pkg::FN_SUB:  return mips_pkg::ALU_SUB;
      mips_pkg::FN_SUBU: return mips_pkg::ALU_SUBU;
      mips_pkg::FN_AND:  return mips_pkg::ALU_AND;
      mips_pkg::FN_OR:   return mips_pkg::ALU_OR;
      mips_pkg::FN_XOR:  return mips_pkg::ALU_XOR;
      mips_pkg::FN_NOR:  return mips_pkg::ALU_NOR;
      mips_pkg::FN_SLT:  return mips_pkg::ALU_SLT;
      mips_pkg::FN_SLTU: return mips_pkg::ALU_SLTU;
      mips_pkg::FN_SLL:  return mips_pkg::ALU_SLL;
      mips_pkg::FN_SRL:  return mips_pkg::ALU_SRL;
      mips_pkg::FN_SRA:  return mips_pkg::ALU_SRA;
      default:           return mips_pkg::ALU_ADD;    // Unlisted funct adds
    endcase
  endfunction

  function automatic mips_pkg::alu_ctrl_t imm_alu(input mips_pkg::opcode_t op);
    case (op)
      mips_pkg::OP_ADDIU: return mips_pkg::ALU_ADDU;
      mips_pkg::OP_ANDI:  return mips_pkg::ALU_AND;
      mips_pkg::OP_ORI:   return mips_pkg::ALU_OR;
      mips_pkg::OP_XORI:  return mips_pkg::ALU_XOR;
      mips_pkg::OP_SLTI:  return mips_pkg::ALU_SLT;
      mips_pkg::OP_SLTIU: return mips_pkg::ALU_SLTU;
      default:            return mips_pkg::ALU_LUI;
    endcase
  endfunction

  // Expected ID/EX contents for one instruction, reads from the model
  function automatic exp_t ref_decode(input mips_pkg::word_t ins);
    exp_t                e;
    mips_pkg::opcode_t   op;
    mips_pkg::reg_addr_t rt;
    mips_pkg::imm_t      imm;
    op  = ins[31:26];
    rt  = ins[20:16];
    imm = ins[15:0];
    e   = '0;
    e.dst      = rt;                                  // Default target field
    e.alu_ctrl = mips_pkg::ALU_ADD;
    case (op)
      mips_pkg::OP_RTYPE: begin
        case (ins[5:0])
          mips_pkg::FN_JR: {e.jump, e.jump_reg} = 2'b11;
          mips_pkg::FN_JALR: begin
            {e.jump, e.jump_reg, e.reg_write} = 3'b111;
            e.dst = mips_pkg::RA_REG;
          end
          mips_pkg::FN_MTHI, mips_pkg::FN_MTLO: ;    // No GPR write
          default: begin
            e.reg_write = 1'b1;
            e.dst       = ins[15:11];
          end
        endcase
        case (ins[5:0])
          mips_pkg::FN_JR, mips_pkg::FN_JALR, mips_pkg::FN_MTHI, mips_pkg::FN_MTLO:
            e.alu_ctrl = mips_pkg::ALU_PASSA;
          default: e.alu_ctrl = funct_alu(ins[5:0]);
        endcase
      end
      mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_LH, mips_pkg::OP_LHU,
      mips_pkg::OP_LW, mips_pkg::OP_LWL, mips_pkg::OP_LWR:
        {e.reg_write, e.alu_src, e.mem_to_reg} = 3'b111;
      mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW:
        {e.alu_src, e.mem_write} = 2'b11;
      mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ: begin
        e.branch   = 1'b1;
        e.alu_ctrl = mips_pkg::ALU_SUB;
      end
      mips_pkg::OP_REGIMM: begin
        if (rt == mips_pkg::RT_BLTZ || rt == mips_pkg::RT_BGEZ) begin
          e.branch   = 1'b1;
          e.alu_ctrl = mips_pkg::ALU_SUB;
        end else if (rt == mips_pkg::RT_BLTZAL || rt == mips_pkg::RT_BGEZAL) begin
          {e.branch, e.reg_write} = 2'b11;            // Link form
          e.dst      = mips_pkg::RA_REG;
          e.alu_ctrl = mips_pkg::ALU_SUB;
        end else begin
          e.illegal = 1'b1;
        end
      end
      mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI,
      mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
        {e.reg_write, e.alu_src} = 2'b11;
        e.alu_ctrl = imm_alu(op);
      end
      mips_pkg::OP_J: e.jump = 1'b1;
      mips_pkg::OP_JAL: begin
        {e.jump, e.reg_write} = 2'b11;
        e.dst = mips_pkg::RA_REG;
      end
      default: e.illegal = 1'b1;                      // Undefined opcode
    endcase
    case (op)
      mips_pkg::OP_LBU: e.load_ctrl = mips_pkg::LD_BU;
      mips_pkg::OP_LH:  e.load_ctrl = mips_pkg::LD_H;
      mips_pkg::OP_LHU: e.load_ctrl = mips_pkg::LD_HU;
      mips_pkg::OP_LW:  e.load_ctrl = mips_pkg::LD_W;
      mips_pkg::OP_LWL: e.load_ctrl = mips_pkg::LD_WL;
      mips_pkg::OP_LWR: e.load_ctrl = mips_pkg::LD_WR;
      default:          e.load_ctrl = mips_pkg::LD_B;
    endcase
    case (op)
      mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: e.imm = {16'h0000, imm};
      mips_pkg::OP_LUI: e.imm = {imm, 16'h0000};
      default:          e.imm = {{16{imm[15]}}, imm};
    endcase
    e.rs_data = rf_model[ins[25:21]];                 // r0 is never written
    e.rt_data = rf_model[rt];
    return e;
  endfunction

  function automatic mips_pkg::word_t rand_instr();
    mips_pkg::word_t w;
    int unsigned     pick;
    w    = $random(seed);
    pick = $random(seed);
    if (w[31:30] != 2'b01) w[31:26] = op_list[pick % 25];  // Mostly defined ops
    return w;
  endfunction

  // One cycle of stimulus, 2 ns after the edge
  task automatic step(input logic v, input mips_pkg::word_t ins, input logic we,
                      input mips_pkg::reg_addr_t wa, input mips_pkg::word_t wd);
    @(posedge clk);
    #2;
    instr_valid = v;
    instr       = ins;
    wb_en       = we;
    wb_addr     = wa;
    wb_data     = wd;
    if (we && wa != 5'd0) rf_model[wa] = wd;          // Seen by last slot's read
    if (prev_valid) exp_q.push_back(ref_decode(prev_instr));
    prev_valid = v;
    prev_instr = ins;
  endtask

  task automatic issue(input mips_pkg::word_t ins);
    step(1'b1, ins, 1'b0, 5'd0, 32'h0);
  endtask

  always @(negedge clk) begin
    exp_t e;
    if (rst_n) begin
      check_bit("ex_valid", v_hist[1], ex_valid);     // Two cycles behind the strobe
      if (ex_valid) begin
        if (exp_q.size() == 0) begin
          $display("ex_valid was high at %0t ns with no instruction expected", $time);
          abort_run();
        end
        e = exp_q.pop_front();
        check_bit("ex_reg_write", e.reg_write, ex_reg_write);
        check_dst("ex_dst", e.dst, ex_dst);
        check_bit("ex_alu_src", e.alu_src, ex_alu_src);
        check_bit("ex_branch", e.branch, ex_branch);
        check_bit("ex_mem_write", e.mem_write, ex_mem_write);
        check_bit("ex_mem_to_reg", e.mem_to_reg, ex_mem_to_reg);
        check_bit("ex_jump", e.jump, ex_jump);
        check_bit("ex_jump_reg", e.jump_reg, ex_jump_reg);
        check_alu("ex_alu_ctrl", e.alu_ctrl, ex_alu_ctrl);
        check_load("ex_load_ctrl", e.load_ctrl, ex_load_ctrl);
        check_bit("ex_illegal", e.illegal, ex_illegal);
        check_word("ex_rs_data", e.rs_data, ex_rs_data);
        check_word("ex_rt_data", e.rt_data, ex_rt_data);
        check_word("ex_imm", e.imm, ex_imm);
      end else begin
        check_bit("ex_reg_write", 1'b0, ex_reg_write);  // Bubble writes nothing
        check_bit("ex_mem_write", 1'b0, ex_mem_write);
      end
    end
    v_hist = {v_hist[0], instr_valid};
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYC) begin
      $display("Run stopped after %0d cycles without finishing", TIMEOUT_CYC);
      abort_run();
    end
  end

  initial begin
    mips_pkg::word_t   r;
    mips_pkg::opcode_t imm_ops [0:6];
    logic [19:0]       gap_pat;
    seed        = 66855;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    wb_en       = 1'b0;
    wb_addr     = '0;
    wb_data     = '0;
    prev_valid  = 1'b0;
    prev_instr  = '0;
    imm_ops     = '{mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI,
                    mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_LW};
    gap_pat     = 20'b1101_1001_1100_0101_0111;
    for (int i = 0; i < 32; i++) rf_model[i] = '0;
    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;

    for (int op = 0; op < 64; op++) begin             // Every opcode, random fields
      r = $random(seed);
      issue({6'(op), r[25:0]});
    end
    for (int fn = 0; fn < 64; fn++) begin             // Every funct code
      r = $random(seed);
      issue({mips_pkg::OP_RTYPE, r[25:6], 6'(fn)});
    end
    for (int rt = 0; rt < 32; rt++) begin             // REGIMM selectors
      r = $random(seed);
      issue({mips_pkg::OP_REGIMM, r[25:21], 5'(rt), r[15:0]});
    end
    for (int j = 0; j < 7; j++) begin                 // Bit 15 set, then clear
      r = $random(seed);
      issue({imm_ops[j], r[25:16], 16'h8001});
      issue({imm_ops[j], r[25:16], 16'h7ffe});
    end

    for (int i = 1; i < 32; i++) step(1'b0, rand_instr(), 1'b1, 5'(i), $random(seed));
    step(1'b0, rand_instr(), 1'b1, 5'd0, $random(seed));  // Dropped by r0
    for (int i = 0; i < 32; i += 2) begin
      issue({mips_pkg::OP_RTYPE, 5'(i), 5'(i + 1), 5'd3, 5'd0, mips_pkg::FN_ADDU});
    end
    issue({mips_pkg::OP_RTYPE, 5'd9, 5'd9, 5'd4, 5'd0, mips_pkg::FN_OR});
    step(1'b1, {mips_pkg::OP_SW, 5'd9, 5'd12, 16'h0010}, 1'b1, 5'd9, $random(seed));
    step(1'b0, rand_instr(), 1'b1, 5'd12, $random(seed));  // Bypass into the SW read

    for (int i = 0; i < 20; i++) step(gap_pat[i], rand_instr(), 1'b0, 5'd0, 32'h0);

    for (int i = 0; i < 300; i++) begin               // Random mix, ~3/4 strobed
      r = $random(seed);
      step(r[1:0] != 2'b00, rand_instr(), r[2], r[7:3], $random(seed));
    end

    repeat (4) step(1'b0, rand_instr(), 1'b0, 5'd0, 32'h0);  // Drain the pipe
    if (exp_q.size() != 0 || UUT.u_decode.u_asrt.n_fail != 0) begin
      $display("%0d expected results never appeared, %0d assertion failures",
               exp_q.size(), UUT.u_decode.u_asrt.n_fail);
      abort_run();
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

//--- mips_decode_top.f
mips_pkg.sv
ctrl_if.sv
maindec.sv
aludec.sv
regfile.sv
decode_stage.sv
mips_decode_top.sv
mips_decode_assertions.sv
tb_mips_decode.sv
